// File: hw/htif_pkg.sv
`default_nettype none

package htif_pkg;

   // Address advance after every bus read or write.
   localparam int ADDR_STEP = 4;

   // Bus memory geometry. The word index is taken from address bits above the byte offset.
   localparam int MEM_WORDS = 64;
   localparam int MEM_IDX_W = $clog2(MEM_WORDS);

   // Cycles from an accepted read to its response.
   localparam int READ_LATENCY = 2;

   // Host receive buffer.
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // Host command bytes, ASCII.
   typedef enum logic [7:0] {
      CMD_ADDR  = 8'h61,
      CMD_READ  = 8'h72,
      CMD_WRITE = 8'h77
   } htif_cmd_t;

   typedef enum logic [3:0] {
      IDLE,
      GET_B0,
      GET_B1,
      GET_B2,
      GET_B3,
      BUS_REQ,
      WAIT_RES,
      SEND_B0,
      SEND_B1,
      SEND_B2,
      SEND_B3
   } htif_state_t;

endpackage

`default_nettype wire

// File: hw/rx_byte_fifo.sv
`default_nettype none

module rx_byte_fifo (
   input  logic       clock,
   input  logic       arst_n,
   input  logic       rx_valid,
   input  logic [7:0] rx_data,
   output logic       rx_ready,
   output logic       fifo_valid,
   output logic [7:0] fifo_data,
   input  logic       fifo_ready
);
   import htif_pkg::*;

   logic [7:0]            buffer [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  push;
   logic                  pop;

   // Host side stalls only when every entry is taken.
   assign rx_ready   = count != FIFO_CNT_W'(FIFO_DEPTH);
   assign fifo_valid = count != '0;
   // Fall-through read port.
   assign fifo_data  = buffer[rd_ptr];

   assign push = rx_valid & rx_ready;
   assign pop  = fifo_valid & fifo_ready;

   always_ff @(posedge clock) begin
      if (push) begin
         buffer[wr_ptr] <= rx_data;
      end
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            if (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop) begin
            if (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         // Simultaneous push and pop leave the count unchanged.
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/htif_bridge.sv
`default_nettype none

module htif_bridge (
   input  logic        clock,
   input  logic        arst_n,
   input  logic        fifo_valid,
   input  logic [7:0]  fifo_data,
   output logic        fifo_ready,
   input  logic        bus_req_ready,
   output logic        bus_req_read,
   output logic        bus_req_write,
   output logic [31:0] bus_req_address,
   output logic [31:0] bus_req_data,
   input  logic        bus_res_valid,
   input  logic [31:0] bus_res_data,
   input  logic        tx_ready,
   output logic        tx_valid,
   output logic [7:0]  tx_data
);
   import htif_pkg::*;

   htif_state_t state;
   htif_cmd_t   cmd;
   logic [31:0] data;
   logic        rx_go;
   logic        tx_go;

   // Host bytes are taken only while idle or collecting a payload.
   assign fifo_ready = (state == IDLE) || (state == GET_B0) || (state == GET_B1) ||
                       (state == GET_B2) || (state == GET_B3);

   assign bus_req_read  = (state == BUS_REQ) && (cmd == CMD_READ);
   assign bus_req_write = (state == BUS_REQ) && (cmd == CMD_WRITE);
   assign bus_req_data  = data;

   assign tx_valid = (state == SEND_B0) || (state == SEND_B1) ||
                     (state == SEND_B2) || (state == SEND_B3);

   assign rx_go = fifo_valid & fifo_ready;
   assign tx_go = tx_valid & tx_ready;

   // Read word goes out least significant byte first.
   always_comb begin
      case (state)
         SEND_B1: tx_data = data[15:8];
         SEND_B2: tx_data = data[23:16];
         SEND_B3: tx_data = data[31:24];
         default: tx_data = data[7:0];
      endcase
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state           <= IDLE;
         cmd             <= CMD_ADDR;
         bus_req_address <= '0;
      end else begin
         case (state)
            IDLE: begin
               // Anything other than a known opcode is consumed and dropped.
               if (rx_go) begin
                  case (fifo_data)
                     CMD_ADDR: begin
                        cmd   <= CMD_ADDR;
                        state <= GET_B0;
                     end
                     CMD_WRITE: begin
                        cmd   <= CMD_WRITE;
                        state <= GET_B0;
                     end
                     CMD_READ: begin
                        cmd   <= CMD_READ;
                        state <= BUS_REQ;
                     end
                     default: state <= IDLE;
                  endcase
               end
            end
            GET_B0: if (rx_go) state <= GET_B1;
            GET_B1: if (rx_go) state <= GET_B2;
            GET_B2: if (rx_go) state <= GET_B3;
            GET_B3: begin
               if (rx_go) begin
                  if (cmd == CMD_ADDR) begin
                     bus_req_address <= {fifo_data, data[23:0]};
                     state           <= IDLE;
                  end else begin
                     state <= BUS_REQ;
                  end
               end
            end
            BUS_REQ: begin
               if (bus_req_ready) begin
                  bus_req_address <= bus_req_address + 32'(ADDR_STEP);
                  if (cmd == CMD_READ) begin
                     state <= WAIT_RES;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            WAIT_RES: if (bus_res_valid) state <= SEND_B0;
            SEND_B0:  if (tx_go) state <= SEND_B1;
            SEND_B1:  if (tx_go) state <= SEND_B2;
            SEND_B2:  if (tx_go) state <= SEND_B3;
            SEND_B3:  if (tx_go) state <= IDLE;
            default:  state <= IDLE;
         endcase
      end
   end

   // Payload register, shared by address, write data and read data.
   always_ff @(posedge clock) begin
      if (rx_go) begin
         case (state)
            GET_B0: data[7:0]   <= fifo_data;
            GET_B1: data[15:8]  <= fifo_data;
            GET_B2: data[23:16] <= fifo_data;
            GET_B3: data[31:24] <= fifo_data;
            default: data <= data;
         endcase
      end else if (state == WAIT_RES && bus_res_valid) begin
         data <= bus_res_data;
      end
   end

endmodule

`default_nettype wire

// File: hw/bus_memory.sv
`default_nettype none

module bus_memory (
   input  logic        clock,
   input  logic        arst_n,
   output logic        bus_req_ready,
   input  logic        bus_req_read,
   input  logic        bus_req_write,
   input  logic [31:0] bus_req_address,
   input  logic [31:0] bus_req_data,
   output logic        bus_res_valid,
   output logic [31:0] bus_res_data
);
   import htif_pkg::*;

   logic [31:0]          mem [MEM_WORDS];
   logic [MEM_IDX_W-1:0] word_idx;
   logic                 busy;
   logic                 accept;
   logic                 rd_accept;
   logic [READ_LATENCY-1:0] res_valid_q;
   logic [31:0]          res_data_q [READ_LATENCY];

   // Byte offset bits are ignored and upper bits alias.
   assign word_idx = bus_req_address[MEM_IDX_W+1:2];

   assign bus_req_ready = !busy;
   assign accept        = bus_req_ready & (bus_req_read | bus_req_write);
   assign rd_accept     = bus_req_ready & bus_req_read;

   assign bus_res_valid = res_valid_q[READ_LATENCY-1];
   assign bus_res_data  = res_data_q[READ_LATENCY-1];

   // One dead cycle after every accepted request.
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         busy        <= 1'b0;
         res_valid_q <= '0;
      end else begin
         busy           <= accept;
         res_valid_q[0] <= rd_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            res_valid_q[i] <= res_valid_q[i-1];
         end
      end
   end

   always_ff @(posedge clock) begin
      if (accept && bus_req_write) begin
         mem[word_idx] <= bus_req_data;
      end
   end

   // Read data moves alongside its valid bit.
   always_ff @(posedge clock) begin
      res_data_q[0] <= mem[word_idx];
      for (int i = 1; i < READ_LATENCY; i++) begin
         res_data_q[i] <= res_data_q[i-1];
      end
   end

endmodule

`default_nettype wire

// File: hw/htif_top.sv
`default_nettype none

module htif_top (
   input  logic       clock,
   input  logic       arst_n,
   input  logic       rx_valid,
   input  logic [7:0] rx_data,
   output logic       rx_ready,
   input  logic       tx_ready,
   output logic       tx_valid,
   output logic [7:0] tx_data
);

   logic        fifo_valid;
   logic [7:0]  fifo_data;
   logic        fifo_ready;
   logic        bus_req_ready;
   logic        bus_req_read;
   logic        bus_req_write;
   logic [31:0] bus_req_address;
   logic [31:0] bus_req_data;
   logic        bus_res_valid;
   logic [31:0] bus_res_data;

   rx_byte_fifo u_rx_fifo (
      .clock      (clock),
      .arst_n     (arst_n),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_ready   (rx_ready),
      .fifo_valid (fifo_valid),
      .fifo_data  (fifo_data),
      .fifo_ready (fifo_ready)
   );

   htif_bridge u_bridge (
      .clock           (clock),
      .arst_n          (arst_n),
      .fifo_valid      (fifo_valid),
      .fifo_data       (fifo_data),
      .fifo_ready      (fifo_ready),
      .bus_req_ready   (bus_req_ready),
      .bus_req_read    (bus_req_read),
      .bus_req_write   (bus_req_write),
      .bus_req_address (bus_req_address),
      .bus_req_data    (bus_req_data),
      .bus_res_valid   (bus_res_valid),
      .bus_res_data    (bus_res_data),
      .tx_ready        (tx_ready),
      .tx_valid        (tx_valid),
      .tx_data         (tx_data)
   );

   bus_memory u_memory (
      .clock           (clock),
      .arst_n          (arst_n),
      .bus_req_ready   (bus_req_ready),
      .bus_req_read    (bus_req_read),
      .bus_req_write   (bus_req_write),
      .bus_req_address (bus_req_address),
      .bus_req_data    (bus_req_data),
      .bus_res_valid   (bus_res_valid),
      .bus_res_data    (bus_res_data)
   );

endmodule

`default_nettype wire

// File: bench/htif_checker.sv
`default_nettype none

module htif_checker (
   input  logic       clock,
   input  logic       arst_n,
   input  logic       rx_valid,
   input  logic [7:0] rx_data,
   input  logic       rx_ready,
   input  logic       tx_valid,
   input  logic [7:0] tx_data,
   input  logic       tx_ready,
   input  logic       test_end,
   input  int         test_num,
   output int         pending,
   output int         errors,
   output int         compared
);
   timeunit 1ns;
   timeprecision 1ps;
   import htif_pkg::*;

   logic [31:0] model_mem [MEM_WORDS];
   logic [31:0] model_addr;
   logic [31:0] model_word;
   htif_cmd_t   model_cmd;
   int          payload_left;
   logic [7:0]  exp_q [$];
   int          err_total;
   int          byte_total;
   int          test_errors;
   int          test_bytes;

   // Protocol model. Every accepted host byte passes through here and each read
   // queues the four bytes the host should get back, least significant first.
   function automatic void model_host_byte(input logic [7:0] b);
      logic [31:0] word;
      if (payload_left == 0) begin
         case (b)
            CMD_ADDR: begin
               model_cmd    = CMD_ADDR;
               payload_left = 4;
            end
            CMD_WRITE: begin
               model_cmd    = CMD_WRITE;
               payload_left = 4;
            end
            CMD_READ: begin
               word = model_mem[model_addr[MEM_IDX_W+1:2]];
               for (int i = 0; i < 4; i++) begin
                  exp_q.push_back(word[8*i +: 8]);
               end
               model_addr = model_addr + 32'(ADDR_STEP);
            end
            default: begin
               // Unknown command bytes are dropped.
            end
         endcase
      end else begin
         model_word   = {b, model_word[31:8]};
         payload_left = payload_left - 1;
         if (payload_left == 0 && model_cmd == CMD_ADDR) begin
            model_addr = model_word;
         end else if (payload_left == 0) begin
            // Same aliasing as the bus memory, modulo 256 bytes.
            model_mem[model_addr[MEM_IDX_W+1:2]] = model_word;
            model_addr = model_addr + 32'(ADDR_STEP);
         end
      end
   endfunction

   function automatic void count_error();
      test_errors = test_errors + 1;
      err_total   = err_total + 1;
   endfunction

   always @(posedge clock) begin
      logic [7:0] exp_byte;
      if (!arst_n) begin
         exp_q.delete();
         payload_left = 0;
         model_addr   = '0;
         model_word   = '0;
         model_cmd    = CMD_ADDR;
      end else begin
         if (tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
               $display("test %0d: tx byte %02h sent with no read outstanding", test_num, tx_data);
               count_error();
            end else begin
               exp_byte   = exp_q.pop_front();
               test_bytes = test_bytes + 1;
               byte_total = byte_total + 1;
               if (tx_data !== exp_byte) begin
                  $display("FAIL tx_data: got %02h, expected %02h", tx_data, exp_byte);
                  count_error();
               end
            end
         end
         if (rx_valid && rx_ready) begin
            model_host_byte(rx_data);
         end
         // Every test ends with the bridge idle and nothing left to send.
         if (test_end) begin
            if (exp_q.size() != 0) begin
               $display("test %0d: %0d expected bytes never arrived", test_num, exp_q.size());
               count_error();
            end
            if (!rx_ready) begin
               $display("test %0d: rx_ready is low while the host is idle", test_num);
               count_error();
            end
            if (tx_valid) begin
               $display("test %0d: tx_valid is high with no read outstanding", test_num);
               count_error();
            end
            $display("test %0d: %0d bytes compared, %0d errors", test_num, test_bytes, test_errors);
            test_bytes  = 0;
            test_errors = 0;
         end
      end
      pending  <= exp_q.size();
      errors   <= err_total;
      compared <= byte_total;
   end

endmodule

`default_nettype wire

// File: bench/htif_tb.sv
`default_nettype none

module htif_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import htif_pkg::*;

   localparam logic [31:0] SEED = 32'hb3dd065f;
   localparam int RANDOM_CMDS = 150;
   // Commands per test. The random test adds its memory fill and a final read.
   localparam int NUM_CMDS = 10 + 4 + 12 + 13 + (1 + MEM_WORDS + RANDOM_CMDS + 1);
   // 40 cycles per command plus the read latency, doubled for gaps and stalls.
   localparam int WATCHDOG_CYCLES = 2 * (NUM_CMDS * 40 + NUM_CMDS * READ_LATENCY);
   // Longest wait for the last read bytes once the host has sent everything.
   localparam int DRAIN_CYCLES = 500;

   logic        clock = 1'b0;
   logic        arst_n;
   logic        rx_valid;
   logic [7:0]  rx_data;
   logic        rx_ready;
   logic        tx_ready;
   logic        tx_valid;
   logic [7:0]  tx_data;
   logic        test_end;
   logic        tx_random;
   logic        rx_gaps;
   logic [31:0] stim_lfsr;
   logic [31:0] tx_lfsr;
   int          test_num;
   int          pending;
   int          errors;
   int          compared;

   always #10 clock = ~clock;

   htif_top DUT (
      .clock    (clock),
      .arst_n   (arst_n),
      .rx_valid (rx_valid),
      .rx_data  (rx_data),
      .rx_ready (rx_ready),
      .tx_ready (tx_ready),
      .tx_valid (tx_valid),
      .tx_data  (tx_data)
   );

   htif_checker u_check (
      .clock    (clock),
      .arst_n   (arst_n),
      .rx_valid (rx_valid),
      .rx_data  (rx_data),
      .rx_ready (rx_ready),
      .tx_valid (tx_valid),
      .tx_data  (tx_data),
      .tx_ready (tx_ready),
      .test_end (test_end),
      .test_num (test_num),
      .pending  (pending),
      .errors   (errors),
      .compared (compared)
   );

   // Galois LFSR, one step per random bit.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < count; i++) begin
         stim_lfsr = lfsr_next(stim_lfsr);
         r = {r[30:0], stim_lfsr[0]};
      end
      return r;
   endfunction

   // One host byte, held on the port until the FIFO takes it.
   task automatic send_byte(input logic [7:0] b);
      if (rx_gaps) begin
         repeat (rand_bits(2)) @(posedge clock);
      end
      rx_valid <= 1'b1;
      rx_data  <= b;
      @(posedge clock);
      while (!rx_ready) begin
         @(posedge clock);
      end
      rx_valid <= 1'b0;
   endtask

   task automatic send_word(input logic [31:0] w);
      for (int i = 0; i < 4; i++) begin
         send_byte(w[8*i +: 8]);
      end
   endtask

   task automatic set_address(input logic [31:0] a);
      send_byte(CMD_ADDR);
      send_word(a);
   endtask

   task automatic write_word(input logic [31:0] d);
      send_byte(CMD_WRITE);
      send_word(d);
   endtask

   task automatic read_word();
      send_byte(CMD_READ);
   endtask

   task automatic begin_test(input int n);
      test_num <= n;
   endtask

   // Waits for the expected bytes to come back, within a limit, then flags the end
   // to the checker.
   task automatic finish_test();
      int waited;
      waited = 0;
      @(posedge clock);
      while (pending != 0 && waited < DRAIN_CYCLES) begin
         @(posedge clock);
         waited = waited + 1;
      end
      test_end <= 1'b1;
      @(posedge clock);
      test_end <= 1'b0;
      @(posedge clock);
   endtask

   // Host side back-pressure on the transmit port.
   initial begin
      tx_lfsr = SEED;
      tx_ready <= 1'b1;
      forever begin
         @(posedge clock);
         if (tx_random) begin
            tx_lfsr = lfsr_next(tx_lfsr);
            tx_ready <= tx_lfsr[0];
         end else begin
            tx_ready <= 1'b1;
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clock);
      $display("timeout: DUT stopped responding");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int sel;
      stim_lfsr = SEED;
      rx_gaps   = 1'b0;
      arst_n    <= 1'b0;
      rx_valid  <= 1'b0;
      rx_data   <= 8'h00;
      test_end  <= 1'b0;
      test_num  <= 0;
      tx_random <= 1'b0;
      repeat (2) @(posedge clock);
      arst_n <= 1'b1;

      // Idle state straight out of reset.
      begin_test(1);
      finish_test();

      // Four writes, then the same words read back in order.
      begin_test(2);
      set_address(32'h0000_0040);
      repeat (4) write_word(rand_bits(32));
      set_address(32'h0000_0040);
      repeat (4) read_word();
      finish_test();

      // Both addresses land on word 6 of the memory.
      begin_test(3);
      set_address(32'hdead_0f18);
      write_word(rand_bits(32));
      set_address(32'h0000_0018);
      read_word();
      finish_test();

      begin_test(4);
      set_address(32'h0000_0080);
      send_byte(8'h00);
      write_word(rand_bits(32));
      send_byte(8'h41);
      write_word(rand_bits(32));
      send_byte(8'hff);
      send_byte(8'h52);
      set_address(32'h0000_0080);
      send_byte(8'h57);
      read_word();
      send_byte(8'h0d);
      read_word();
      finish_test();

      // Reads and writes mixed under transmit stalls.
      begin_test(5);
      tx_random <= 1'b1;
      set_address(32'h0000_00c0);
      repeat (4) write_word(rand_bits(32));
      set_address(32'h0000_00c0);
      read_word();
      read_word();
      write_word(rand_bits(32));
      read_word();
      write_word(rand_bits(32));
      set_address(32'h0000_00c0);
      read_word();
      finish_test();

      // Memory is filled first so that any random read hits a written word.
      begin_test(6);
      rx_gaps = 1'b1;
      set_address(32'h0000_0000);
      repeat (MEM_WORDS) write_word(rand_bits(32));
      for (int i = 0; i < RANDOM_CMDS; i++) begin
         sel = int'(rand_bits(3));
         if (sel == 0) begin
            set_address(rand_bits(32));
         end else if (sel < 4) begin
            write_word(rand_bits(32));
         end else begin
            read_word();
         end
      end
      read_word();
      finish_test();

      $display("%0d tests run, %0d bytes compared, %0d errors", test_num, compared, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
hw/htif_pkg.sv
hw/rx_byte_fifo.sv
hw/htif_bridge.sv
hw/bus_memory.sv
hw/htif_top.sv
bench/htif_checker.sv
bench/htif_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure.
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module htif_tb -o htif_sim \
   && ./obj_dir/htif_sim > sim.log 2>&1 \
   && cat sim.log \
   && ! grep -q "TEST FAILED" sim.log \
   && echo "simulation passed" \
   || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
